// ==== test/axis_source_patterns.txt ====
// columns: stall cycles before tready, expected tdata, expected tlast (hex)
// three bursts of eight beats
0 00000001 0
0 00000002 0
1 00000003 0
0 00000004 0
2 00000005 0
0 00000006 0
0 00000007 0
3 00000008 1
5 00000001 0
1 00000002 0
0 00000003 0
4 00000004 0
0 00000005 0
2 00000006 0
0 00000007 0
1 00000008 1
0 00000001 0
3 00000002 0
0 00000003 0
0 00000004 0
5 00000005 0
1 00000006 0
2 00000007 0
0 00000008 1

// ==== project.f ====
+incdir+rtl
rtl/stream_gen_pkg.sv
rtl/beat_if.sv
rtl/start_delay.sv
rtl/beat_sequencer.sv
rtl/axis_output_register.sv
rtl/axis_stream_source.sv
test/axis_source_checker.sv
test/tb_axis_stream_source.sv

// ==== Bender.yml ====
package:
  name: axis_stream_source

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/stream_gen_pkg.sv
      - rtl/beat_if.sv
      - rtl/start_delay.sv
      - rtl/beat_sequencer.sv
      - rtl/axis_output_register.sv
      - rtl/axis_stream_source.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/axis_source_checker.sv
      - test/tb_axis_stream_source.sv

// ==== test/tb_axis_stream_source.sv ====
`timescale 1ns/10ps
`include "axis_source_config.svh"
`default_nettype none

module tb_axis_stream_source;
  import stream_gen_pkg::*;

  localparam int BURSTS      = 3;
  localparam int BEATS       = BURSTS * `AXIS_BURST_WORDS;
  localparam int WAIT_CYCLES = 200;

  logic   M_AXIS_ACLK;
  logic   M_AXIS_ARESETN;
  logic   m_axis_tvalid;
  tdata_t m_axis_tdata;
  tstrb_t m_axis_tstrb;
  logic   m_axis_tlast;
  logic   m_axis_tready;

  logic [31:0] pattern [0:3*BEATS-1];  // stall, data, last per beat.

  int     waited;
  int     stall;
  int     burst;
  int     word;
  tdata_t exp_data;
  logic   exp_last;
  string  name;

  axis_stream_source dut0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tstrb   (m_axis_tstrb),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tready  (m_axis_tready)
  );

  bind axis_stream_source axis_source_checker checker0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tstrb   (m_axis_tstrb),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tready  (m_axis_tready)
  );

  initial begin
    M_AXIS_ACLK = 1'b0;
    forever #2 M_AXIS_ACLK = ~M_AXIS_ACLK;
  end

  // lands 1 ns after the edge when outputs have settled.
  task automatic next_cycle();
    @(posedge M_AXIS_ACLK);
    #1;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input string test, input tdata_t expected, input tdata_t actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s expected %h actual %h", test, expected, actual));
    end
  endtask

  task automatic check_last(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error: %s expected %b actual %b", test, expected, actual));
    end
  endtask

  task automatic check_delay(input string test, input int min_cycles, input int actual);
    if (actual < min_cycles) begin
      abort_run($sformatf("** Error: %s expected at least %0d actual %0d",
                          test, min_cycles, actual));
    end
  endtask

  task automatic wait_for_valid(input string test, output int cycles);
    cycles = 0;
    while (m_axis_tvalid !== 1'b1) begin
      if (cycles >= WAIT_CYCLES) begin
        abort_run($sformatf("%s: no beat arrived within %0d cycles", test, WAIT_CYCLES));
      end
      next_cycle();
      cycles++;
    end
  endtask

  // any stream assertion failure ends the run at once.
  always @(dut0.checker0.assert_failures) begin
    if (dut0.checker0.assert_failures != 0) begin
      abort_run("a stream assertion failed during the run");
    end
  end

  initial begin
    M_AXIS_ARESETN = 1'b0;
    m_axis_tready  = 1'b0;
    $readmemh("test/axis_source_patterns.txt", pattern);
    if ($isunknown(pattern[3*BEATS-1])) begin
      abort_run("pattern file is missing or has too few lines");
    end
    repeat (8) @(posedge M_AXIS_ACLK);
    #1;
    M_AXIS_ARESETN = 1'b1;

    for (int i = 0; i < BEATS; i++) begin
      burst    = i / `AXIS_BURST_WORDS;
      word     = i % `AXIS_BURST_WORDS;
      stall    = int'(pattern[3*i]);
      exp_data = tdata_t'(pattern[3*i+1]);
      exp_last = pattern[3*i+2][0];
      name     = $sformatf("burst %0d word %0d", burst, word);

      wait_for_valid(name, waited);
      if (i == 0) begin
        check_delay({name, " start delay"}, `AXIS_START_COUNT, waited);
      end
      repeat (stall) next_cycle();  // back-pressure.
      if (m_axis_tvalid !== 1'b1) begin
        abort_run($sformatf("%s: tvalid dropped before the beat was taken", name));
      end
      check_data({name, " data"}, exp_data, m_axis_tdata);
      check_last({name, " last"}, exp_last, m_axis_tlast);
      m_axis_tready = 1'b1;
      next_cycle();  // transfer on this edge.
      m_axis_tready = 1'b0;
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule : tb_axis_stream_source

`default_nettype wire

// ==== test/axis_source_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module axis_source_checker (
  input wire logic                   M_AXIS_ACLK,
  input wire logic                   M_AXIS_ARESETN,
  input wire logic                   m_axis_tvalid,
  input wire stream_gen_pkg::tdata_t m_axis_tdata,
  input wire stream_gen_pkg::tstrb_t m_axis_tstrb,
  input wire logic                   m_axis_tlast,
  input wire logic                   m_axis_tready
);
  import stream_gen_pkg::*;

  localparam tstrb_t STRB_ALL = '1;

  int assert_failures = 0;

  // a waiting beat holds until it is taken.
  hold_stable: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
  ) else begin
    assert_failures++;
    $error("stream beat changed under back-pressure");
  end

  reset_quiet: assert property (
    @(posedge M_AXIS_ACLK) !M_AXIS_ARESETN |=> !m_axis_tvalid
  ) else begin
    assert_failures++;
    $error("tvalid high during reset");
  end

  strobe_full: assert property (
    @(posedge M_AXIS_ACLK) disable iff (!M_AXIS_ARESETN)
    m_axis_tvalid |-> (m_axis_tstrb == STRB_ALL)
  ) else begin
    assert_failures++;
    $error("tstrb not all ones on a valid beat");
  end

endmodule : axis_source_checker

`default_nettype wire

// ==== rtl/axis_stream_source.sv ====
`timescale 1ns/10ps
`default_nettype none

module axis_stream_source (
  input  wire logic              M_AXIS_ACLK,
  input  wire logic              M_AXIS_ARESETN,
  output logic                   m_axis_tvalid,
  output stream_gen_pkg::tdata_t m_axis_tdata,
  output stream_gen_pkg::tstrb_t m_axis_tstrb,
  output logic                   m_axis_tlast,
  input  wire logic              m_axis_tready
);

  logic burst_start;
  logic burst_done;

  beat_if beat0 ();

  // waits out the start count, then opens a burst.
  start_delay start_delay0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .burst_done     (burst_done),
    .burst_start    (burst_start)
  );

  beat_sequencer beat_sequencer0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .burst_start    (burst_start),
    .burst_done     (burst_done),
    .beat           (beat0.source)
  );

  // one register between the sequencer and the stream pins.
  axis_output_register axis_output_register0 (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .beat           (beat0.sink),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tdata   (m_axis_tdata),
    .m_axis_tstrb   (m_axis_tstrb),
    .m_axis_tlast   (m_axis_tlast),
    .m_axis_tready  (m_axis_tready)
  );

endmodule : axis_stream_source

`default_nettype wire

// ==== rtl/axis_output_register.sv ====
`timescale 1ns/10ps
`default_nettype none

module axis_output_register (
  input  wire logic             M_AXIS_ACLK,
  input  wire logic             M_AXIS_ARESETN,
  beat_if.sink                  beat,
  output logic                  m_axis_tvalid,
  output stream_gen_pkg::tdata_t m_axis_tdata,
  output stream_gen_pkg::tstrb_t m_axis_tstrb,
  output logic                  m_axis_tlast,
  input  wire logic             m_axis_tready
);
  import stream_gen_pkg::*;

  localparam tstrb_t STRB_ALL = '1;

  logic   valid_q;
  tdata_t data_q;
  logic   last_q;
  logic   load;

  // empty slot, or the held word leaves this cycle.
  assign beat.ready = !valid_q || m_axis_tready;
  assign load       = beat.valid && beat.ready;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (m_axis_tready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (load) begin
      data_q <= beat.data;
      last_q <= beat.last;
    end
  end

  assign m_axis_tvalid = valid_q;
  assign m_axis_tdata  = data_q;
  assign m_axis_tlast  = last_q;
  assign m_axis_tstrb  = STRB_ALL;  // every byte valid.

endmodule : axis_output_register

`default_nettype wire

// ==== rtl/beat_sequencer.sv ====
`timescale 1ns/10ps
`include "axis_source_config.svh"
`default_nettype none

module beat_sequencer (
  input  wire logic M_AXIS_ACLK,
  input  wire logic M_AXIS_ARESETN,
  input  wire logic burst_start,
  output logic      burst_done,
  beat_if.source    beat
);
  import stream_gen_pkg::*;

  localparam beat_idx_t LAST_IDX = beat_idx_t'(`AXIS_BURST_WORDS - 1);

  beat_idx_t pointer;       // word index within the burst.
  logic      active;        // burst in progress.
  logic      beat_xfer;
  logic      beat_is_last;

  assign beat_is_last = (pointer == LAST_IDX);
  assign beat_xfer    = beat.valid && beat.ready;

  // beat presented straight from the pointer.
  assign beat.valid = active;
  assign beat.data  = tdata_t'(pointer) + tdata_t'(1);
  assign beat.last  = active && beat_is_last;

  // leaves with the final word.
  assign burst_done = beat_xfer && beat_is_last;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      pointer <= '0;
      active  <= 1'b0;
    end else if (burst_start) begin
      // every burst begins from word zero.
      pointer <= '0;
      active  <= 1'b1;
    end else if (beat_xfer) begin
      pointer <= pointer + 1'b1;
      if (beat_is_last) begin
        active <= 1'b0;
      end
    end
  end

endmodule : beat_sequencer

`default_nettype wire

// ==== rtl/start_delay.sv ====
`timescale 1ns/10ps
`include "axis_source_config.svh"
`default_nettype none

module start_delay (
  input  wire logic M_AXIS_ACLK,
  input  wire logic M_AXIS_ARESETN,
  input  wire logic burst_done,
  output logic      burst_start
);
  import stream_gen_pkg::*;

  localparam int unsigned COUNT_W = $clog2(`AXIS_START_COUNT + 1);
  localparam logic [COUNT_W-1:0] COUNT_LAST = COUNT_W'(`AXIS_START_COUNT - 1);

  start_state_e       state;
  start_state_e       state_next;
  logic [COUNT_W-1:0] count;
  logic               count_done;
  logic               counting;

  assign counting   = (state == INIT_COUNTER);
  assign count_done = counting && (count == COUNT_LAST);

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        state_next = INIT_COUNTER;  // one cycle only.
      end
      INIT_COUNTER: begin
        if (count_done) begin
          state_next = SEND_STREAM;
        end
      end
      SEND_STREAM: begin
        if (burst_done) begin
          state_next = IDLE;  // rearm for the next delay.
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state       <= IDLE;
      count       <= '0;
      burst_start <= 1'b0;
    end else begin
      state       <= state_next;
      // high in the first cycle of SEND_STREAM.
      burst_start <= count_done;
      if (counting && !count_done) begin
        count <= count + 1'b1;
      end else begin
        count <= '0;
      end
    end
  end

endmodule : start_delay

`default_nettype wire

// ==== rtl/beat_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface beat_if;
  import stream_gen_pkg::*;

  logic   valid;  // beat present at the source.
  logic   ready;  // sink can take it.
  tdata_t data;
  logic   last;   // final beat of the burst.

  // sequencer side.
  modport source (
    output valid,
    output data,
    output last,
    input  ready
  );

  // output register side.
  modport sink (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface : beat_if

`default_nettype wire

// ==== rtl/stream_gen_pkg.sv ====
`include "axis_source_config.svh"

`default_nettype none

package stream_gen_pkg;

  // one stream word and its byte strobe.
  typedef logic [`AXIS_TDATA_WIDTH-1:0]   tdata_t;
  typedef logic [`AXIS_TDATA_WIDTH/8-1:0] tstrb_t;

  // index steps to AXIS_BURST_WORDS after the last word.
  typedef logic [$clog2(`AXIS_BURST_WORDS + 1)-1:0] beat_idx_t;

  // start delay FSM states.
  typedef enum logic [1:0] {
    IDLE         = 2'b00,
    INIT_COUNTER = 2'b01,
    SEND_STREAM  = 2'b10
  } start_state_e;

endpackage : stream_gen_pkg

`default_nettype wire

// ==== rtl/axis_source_config.svh ====
`ifndef AXIS_SOURCE_CONFIG_SVH
`define AXIS_SOURCE_CONFIG_SVH

`default_nettype none

// stream data width in bits.
`define AXIS_TDATA_WIDTH 32

// cycles spent counting before each burst.
`define AXIS_START_COUNT 32

// words in each burst.
`define AXIS_BURST_WORDS 8

`default_nettype wire

`endif
